// File: files.f
+incdir+src
src/mcu_periph_pkg.sv
src/mcu_periph_ifs.sv
src/cdc_value_latch.sv
src/dataslot_update_sync.sv
src/ms_timer.sv
src/hps_io_port.sv
src/periph_regs.sv
src/mcu_periph_top.sv
test/mcu_periph_asserts.sv
test/tb_mcu_periph.sv

// File: run.sh
#!/usr/bin/env bash
# build and run tb_mcu_periph with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mcu_periph -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: test/tb_mcu_periph.sv
/*
 * testbench for mcu_periph_top, one bus access at a time
 * expected reads come from ref_read over shadows of the written registers
 * and the driven inputs
 * TIMER and the pending poll are checked by range
 * clk_74a is unrelated to clk_sys, so update latency is only bounded
 */
`default_nettype none
`include "mcu_periph_params.svh"

module tb_mcu_periph;
	timeunit 1ns;
	timeprecision 1ps;
	import mcu_periph_pkg::*;

	// about 80 accesses of 4 cycles plus 100 idle cycles and the polls come to ~600
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [15:0] ALL_REGS [13] = '{`MCU_REG_SLOT_ID, `MCU_REG_SLOT_BRIDGE,
		`MCU_REG_SLOT_LEN, `MCU_REG_SLOT_OFS, `MCU_REG_SLOT_CTRL, `MCU_REG_TICK_PERIOD,
		`MCU_REG_RESET_OUT, `MCU_REG_UPD_PENDING, `MCU_REG_UPD_ID, `MCU_REG_UPD_SIZE,
		`MCU_REG_TIMER, `MCU_REG_HPS_OUT, `MCU_REG_HPS_IN};
	localparam logic [15:0] RW_REGS [7] = '{`MCU_REG_SLOT_ID, `MCU_REG_SLOT_BRIDGE,
		`MCU_REG_SLOT_LEN, `MCU_REG_SLOT_OFS, `MCU_REG_TICK_PERIOD, `MCU_REG_RESET_OUT,
		`MCU_REG_HPS_OUT};

	logic      clk_sys = 1'b0;
	logic      clk_74a = 1'b0;
	logic      reset_n;
	logic      cpu_valid;
	word_t     cpu_addr;
	word_t     cpu_wdata;
	wstrb_t    cpu_wstrb;
	word_t     cpu_rdata;
	logic      cpu_ready;
	logic      reset_out;
	logic      dataslot_update;
	slot_id_t  dataslot_update_id;
	word_t     dataslot_update_size;
	logic      target_dataslot_read;
	logic      target_dataslot_write;
	logic      target_dataslot_ack;
	logic      target_dataslot_done;
	slot_err_t target_dataslot_err;
	slot_id_t  target_dataslot_id;
	word_t     target_dataslot_slotoffset;
	word_t     target_dataslot_bridgeaddr;
	word_t     target_dataslot_length;
	logic      io_uio;
	logic      io_fpga;
	logic      io_strobe;
	logic      io_wait;
	io_data_t  io_din;
	io_data_t  io_dout;
	logic      io_wide;

	integer    seed = 74;
	int        errors = 0;
	int        err_base = 0; // errors before the current test
	int        checks = 0;
	int        tests = 0;
	int        cycles = 0;
	int        rd_pulses = 0;
	int        wr_pulses = 0;
	int        strobe_cycles = 0;
	logic      rd_at_first; // pulses seen one edge into an access
	logic      wr_at_first;
	word_t     cmp_addr_q [$];
	word_t     cmp_got_q [$];
	word_t     cmp_exp_q [$];

	// shadows of what the page should hold
	slot_id_t  sh_slot_id = '0;
	word_t     sh_bridge = '0;
	word_t     sh_len = '0;
	word_t     sh_ofs = '0;
	word_t     sh_tick = '0;
	logic      sh_reset_out = 1'b0;
	hps_ctrl_t sh_hps_ctrl = '0;
	io_data_t  sh_hps_dout = '0;
	logic      sh_hps_ack = 1'b0; // set by the test once the ack has settled
	slot_id_t  sh_upd_id = '0;
	word_t     sh_upd_size = '0;

	mcu_periph_top u_mcu_periph_top (.*);

	always #10 clk_sys = ~clk_sys;
	always #6.75 clk_74a = ~clk_74a; // unrelated to clk_sys

	function automatic word_t page_addr(input logic [15:0] ofs);
		return {`MCU_PAGE_HI, ofs};
	endfunction

	function automatic word_t ref_read(input word_t addr);
		if (addr[31:16] != `MCU_PAGE_HI)
			return '0; // nothing answers outside the page
		case (addr[15:0])
			`MCU_REG_SLOT_ID:     return {16'd0, sh_slot_id};
			`MCU_REG_SLOT_BRIDGE: return sh_bridge;
			`MCU_REG_SLOT_LEN:    return sh_len;
			`MCU_REG_SLOT_OFS:    return sh_ofs;
			`MCU_REG_SLOT_CTRL:
				return {27'd0, target_dataslot_ack, target_dataslot_done, target_dataslot_err};
			`MCU_REG_TICK_PERIOD: return sh_tick;
			`MCU_REG_RESET_OUT:   return {31'd0, sh_reset_out};
			`MCU_REG_UPD_ID:      return {16'd0, sh_upd_id};
			`MCU_REG_UPD_SIZE:    return sh_upd_size;
			`MCU_REG_HPS_OUT:     return {11'd0, sh_hps_ctrl, 1'b0, sh_hps_dout};
			`MCU_REG_HPS_IN:      return {14'd0, sh_hps_ack, io_wide, io_din};
			default:              return '0; // pending and timer compared only when zero
		endcase
	endfunction

	task automatic check_value(input word_t got, input word_t exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("FAIL t=%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("FAIL t=%0t: %s", $time, what);
			errors++;
		end
	endtask

	// one request held until cpu_ready and then one idle cycle
	task automatic bus_access(input word_t addr, input word_t wdata, input wstrb_t wstrb,
		output word_t rdata);
		int n;
		n = 0;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_wstrb = wstrb;
		cpu_valid = 1'b1;
		do begin
			@(posedge clk_sys);
			#1;
			n++;
			if (n == 1) begin
				rd_at_first = target_dataslot_read;
				wr_at_first = target_dataslot_write;
			end
		end while (cpu_ready !== 1'b1 && n < 8);
		rdata = cpu_rdata;
		check_true(cpu_ready === 1'b1, $sformatf("no cpu_ready for address 0x%08h", addr));
		check_value(word_t'(n), 32'd2, "edges to cpu_ready");
		#1;
		cpu_valid = 1'b0;
		cpu_wstrb = '0;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic bus_write(input logic [15:0] ofs, input word_t data);
		word_t unused;
		bus_access(page_addr(ofs), data, 4'hF, unused);
		case (ofs)
			`MCU_REG_SLOT_ID:     sh_slot_id = data[15:0];
			`MCU_REG_SLOT_BRIDGE: sh_bridge = data;
			`MCU_REG_SLOT_LEN:    sh_len = data;
			`MCU_REG_SLOT_OFS:    sh_ofs = data;
			`MCU_REG_TICK_PERIOD: sh_tick = data;
			`MCU_REG_RESET_OUT:   sh_reset_out = data[0];
			`MCU_REG_HPS_OUT: begin
				sh_hps_ctrl = hps_ctrl_t'(data[20:17]);
				sh_hps_dout = data[15:0];
			end
			default: ; // pulses and clears keep no state
		endcase
	endtask

	task automatic bus_read(input word_t addr, input bit compare, output word_t data);
		bus_access(addr, '0, 4'h0, data);
		if (compare) begin
			cmp_addr_q.push_back(addr);
			cmp_got_q.push_back(data);
			cmp_exp_q.push_back(ref_read(addr));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	task automatic finish_test(input string name);
		int n_err;
		@(negedge clk_sys); // queued compares are done by now
		#1;
		n_err = errors - err_base;
		tests++;
		if (n_err == 0)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, n_err);
		err_base = errors;
		@(posedge clk_sys);
		#2;
	endtask

	// compare reads against ref_read
	always @(negedge clk_sys) begin
		word_t a;
		word_t got;
		word_t exp;
		while (cmp_addr_q.size() > 0) begin
			a   = cmp_addr_q.pop_front();
			got = cmp_got_q.pop_front();
			exp = cmp_exp_q.pop_front();
			check_value(got, exp, $sformatf("read 0x%08h", a));
		end
	end

	always @(negedge clk_sys) begin
		if (target_dataslot_read === 1'b1)
			rd_pulses++;
		if (target_dataslot_write === 1'b1)
			wr_pulses++;
		if (io_strobe === 1'b1)
			strobe_cycles++;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d clk_sys cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		word_t     v;
		word_t     rnd;
		hps_ctrl_t ctrl;
		logic      exp_fpga;
		logic      exp_uio;
		int        s0;
		int        s1;
		int        tries;
		reset_n              = 1'b0;
		cpu_valid            = 1'b0;
		cpu_addr             = '0;
		cpu_wdata            = '0;
		cpu_wstrb            = '0;
		dataslot_update      = 1'b0;
		dataslot_update_id   = '0;
		dataslot_update_size = '0;
		target_dataslot_ack  = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err  = '0;
		io_wait              = 1'b0;
		io_din               = '0;
		io_wide              = 1'b0;
		repeat (3) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;
		idle(2);

		// register readback starts from all zero with the timer stopped
		foreach (ALL_REGS[i])
			bus_read(page_addr(ALL_REGS[i]), 1'b1, v);
		foreach (RW_REGS[i]) begin
			rnd = $random(seed);
			bus_write(RW_REGS[i], rnd);
		end
		foreach (RW_REGS[i])
			bus_read(page_addr(RW_REGS[i]), 1'b1, v);
		check_value({16'd0, target_dataslot_id}, {16'd0, sh_slot_id}, "target_dataslot_id");
		check_value(target_dataslot_bridgeaddr, sh_bridge, "target_dataslot_bridgeaddr");
		check_value(target_dataslot_length, sh_len, "target_dataslot_length");
		check_value(target_dataslot_slotoffset, sh_ofs, "target_dataslot_slotoffset");
		check_value({31'd0, reset_out}, {31'd0, sh_reset_out}, "reset_out");
		bus_read(page_addr(16'hFF9C), 1'b1, v); // hole inside the page
		bus_read(32'h0000_1000, 1'b1, v);
		finish_test("register readback");

		// bus timing is checked in every access
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			bus_write(`MCU_REG_SLOT_LEN, rnd);
			bus_read(page_addr(`MCU_REG_SLOT_LEN), 1'b1, v);
		end
		finish_test("bus timing");

		// dataslot command pulses and status
		s0 = rd_pulses;
		s1 = wr_pulses;
		bus_write(`MCU_REG_SLOT_CTRL, 32'd1);
		check_true(rd_at_first === 1'b1, "target_dataslot_read not up before cpu_ready");
		check_value(word_t'(wr_pulses - s1), 32'd0, "write pulse cycles after read command");
		bus_write(`MCU_REG_SLOT_CTRL, 32'd2);
		check_true(wr_at_first === 1'b1, "target_dataslot_write not up before cpu_ready");
		check_value(word_t'(rd_pulses - s0), 32'd1, "read pulse cycles");
		check_value(word_t'(wr_pulses - s1), 32'd1, "write pulse cycles");
		rnd = $random(seed);
		target_dataslot_ack  = rnd[0];
		target_dataslot_done = rnd[1];
		target_dataslot_err  = rnd[4:2];
		bus_read(page_addr(`MCU_REG_SLOT_CTRL), 1'b1, v);
		finish_test("dataslot commands");

		// dataslot update across clk_74a
		rnd = $random(seed);
		@(posedge clk_74a);
		#2;
		dataslot_update      = 1'b1;
		dataslot_update_id   = rnd[15:0];
		dataslot_update_size = $random(seed);
		sh_upd_id            = dataslot_update_id;
		sh_upd_size          = dataslot_update_size;
		@(posedge clk_74a);
		#2;
		dataslot_update = 1'b0;
		@(posedge clk_sys);
		#2;
		v     = '0;
		tries = 0;
		while (v[0] !== 1'b1 && tries < 20) begin
			bus_read(page_addr(`MCU_REG_UPD_PENDING), 1'b0, v);
			tries++;
		end
		check_true(v[0] === 1'b1, "UPD_PENDING did not read 1 within 20 reads");
		bus_read(page_addr(`MCU_REG_UPD_ID), 1'b1, v);
		bus_read(page_addr(`MCU_REG_UPD_SIZE), 1'b1, v);
		bus_read(page_addr(`MCU_REG_UPD_PENDING), 1'b1, v); // cleared by the poll
		finish_test("dataslot update");

		// timer over 10 ms of P + 1 cycles
		bus_write(`MCU_REG_TICK_PERIOD, 32'd9);
		bus_write(`MCU_REG_TIMER, 32'd1);
		idle(10 * (9 + 1));
		bus_read(page_addr(`MCU_REG_TIMER), 1'b0, v);
		check_true(v >= 9 && v <= 11, $sformatf("timer read %0d, outside 9 to 11", v));
		finish_test("timer");

		// HPS selects for every ss2..ss0 and io_clk pattern
		for (int c = 0; c < 16; c++) begin
			ctrl     = hps_ctrl_t'(c[3:0]);
			rnd      = $random(seed);
			exp_fpga = ~ctrl.ss1 & ctrl.ss0;
			exp_uio  = ~ctrl.ss1 & ctrl.ss2;
			bus_write(`MCU_REG_HPS_OUT, {11'd0, ctrl, 1'b0, rnd[15:0]});
			check_value({31'd0, io_fpga}, {31'd0, exp_fpga}, "io_fpga");
			check_value({31'd0, io_uio}, {31'd0, exp_uio}, "io_uio");
			check_value({16'd0, io_dout}, {16'd0, rnd[15:0]}, "io_dout");
		end
		bus_write(`MCU_REG_HPS_OUT, 32'd0); // io_clk low so rack and ack follow
		idle(2);
		io_wait = 1'b1;
		s0      = strobe_cycles;
		bus_write(`MCU_REG_HPS_OUT, 32'h0002_0000); // io_clk only
		check_value(word_t'(strobe_cycles - s0), 32'd1, "io_strobe cycles under io_wait");
		bus_read(page_addr(`MCU_REG_HPS_IN), 1'b0, v);
		check_true(v[17] === 1'b0, "HPS ack moved while io_wait was high");
		rnd     = $random(seed);
		io_din  = rnd[15:0];
		io_wide = 1'b1;
		io_wait = 1'b0;
		v       = '0;
		tries   = 0;
		while (v[17] !== 1'b1 && tries < 10) begin
			bus_read(page_addr(`MCU_REG_HPS_IN), 1'b0, v);
			tries++;
		end
		check_true(v[17] === 1'b1, "HPS ack not seen within 10 reads after io_wait dropped");
		sh_hps_ack = 1'b1;
		bus_read(page_addr(`MCU_REG_HPS_IN), 1'b1, v);
		finish_test("HPS port");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/mcu_periph_asserts.sv
/*
 * bus and command pulse properties, bound into periph_regs
 * sampled on clk_sys, off while reset_n is low
 */
`default_nettype none

module mcu_periph_asserts (
	input wire clk_sys,
	input wire reset_n,
	input wire cpu_valid,
	input wire cpu_ready,
	input wire target_dataslot_read,
	input wire target_dataslot_write
);
	timeunit 1ns;
	timeprecision 1ps;

	ready_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ready |=> !cpu_ready)
		else $error("cpu_ready high for more than one cycle");

	read_pulse_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_read |=> !target_dataslot_read)
		else $error("target_dataslot_read high for more than one cycle");

	write_pulse_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_write |=> !target_dataslot_write)
		else $error("target_dataslot_write high for more than one cycle");

	// master may drop valid right after ready, so look one edge back
	ready_needs_valid: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ready |-> $past(cpu_valid))
		else $error("cpu_ready without a request");

endmodule

bind periph_regs mcu_periph_asserts u_mcu_periph_asserts (
	.clk_sys              (clk_sys),
	.reset_n              (reset_n),
	.cpu_valid            (cpu_valid),
	.cpu_ready            (cpu_ready),
	.target_dataslot_read (target_dataslot_read),
	.target_dataslot_write(target_dataslot_write)
);

`default_nettype wire

// File: src/mcu_periph_top.sv
/*
 * memory mapped peripheral block, driven by an external bus master
 * clk_74a is only used for the dataslot update inputs, which must be
 * stable in clk_74a around the dataslot_update pulse
 * reset_n resets both clock domains
 */
`default_nettype none

module mcu_periph_top (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire                            clk_74a,
	input  wire                            cpu_valid,
	input  wire mcu_periph_pkg::word_t     cpu_addr,
	input  wire mcu_periph_pkg::word_t     cpu_wdata,
	input  wire mcu_periph_pkg::wstrb_t    cpu_wstrb,
	output mcu_periph_pkg::word_t          cpu_rdata,
	output logic                           cpu_ready,
	output logic                           reset_out,
	input  wire                            dataslot_update,
	input  wire mcu_periph_pkg::slot_id_t  dataslot_update_id,
	input  wire mcu_periph_pkg::word_t     dataslot_update_size,
	output logic                           target_dataslot_read,
	output logic                           target_dataslot_write,
	input  wire                            target_dataslot_ack,
	input  wire                            target_dataslot_done,
	input  wire mcu_periph_pkg::slot_err_t target_dataslot_err,
	output mcu_periph_pkg::slot_id_t       target_dataslot_id,
	output mcu_periph_pkg::word_t          target_dataslot_slotoffset,
	output mcu_periph_pkg::word_t          target_dataslot_bridgeaddr,
	output mcu_periph_pkg::word_t          target_dataslot_length,
	output logic                           io_uio,
	output logic                           io_fpga,
	output logic                           io_strobe,
	input  wire                            io_wait,
	input  wire mcu_periph_pkg::io_data_t  io_din,
	output mcu_periph_pkg::io_data_t       io_dout,
	input  wire                            io_wide // 1 = 16 bit
);
	import mcu_periph_pkg::*;

	word_t tick_period;
	word_t timer_count;
	logic  timer_clear;

	dataslot_evt_if evt_if ();
	hps_io_if       hps_if ();

	periph_regs u_periph_regs (
		.clk_sys                   (clk_sys),
		.reset_n                   (reset_n),
		.cpu_valid                 (cpu_valid),
		.cpu_addr                  (cpu_addr),
		.cpu_wdata                 (cpu_wdata),
		.cpu_wstrb                 (cpu_wstrb),
		.cpu_rdata                 (cpu_rdata),
		.cpu_ready                 (cpu_ready),
		.target_dataslot_read      (target_dataslot_read),
		.target_dataslot_write     (target_dataslot_write),
		.target_dataslot_ack       (target_dataslot_ack),
		.target_dataslot_done      (target_dataslot_done),
		.target_dataslot_err       (target_dataslot_err),
		.target_dataslot_id        (target_dataslot_id),
		.target_dataslot_slotoffset(target_dataslot_slotoffset),
		.target_dataslot_bridgeaddr(target_dataslot_bridgeaddr),
		.target_dataslot_length    (target_dataslot_length),
		.reset_out                 (reset_out),
		.io_wide                   (io_wide),
		.io_din                    (io_din),
		.tick_period               (tick_period),
		.timer_count               (timer_count),
		.timer_clear               (timer_clear),
		.evt                       (evt_if.consumer),
		.hps                       (hps_if.controller)
	);

	dataslot_update_sync u_dataslot_update_sync (
		.clk_sys             (clk_sys),
		.clk_74a             (clk_74a),
		.reset_n             (reset_n),
		.dataslot_update     (dataslot_update),
		.dataslot_update_id  (dataslot_update_id),
		.dataslot_update_size(dataslot_update_size),
		.evt                 (evt_if.producer)
	);

	ms_timer u_ms_timer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.tick_period(tick_period),
		.clear      (timer_clear),
		.count      (timer_count)
	);

	hps_io_port u_hps_io_port (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.hps      (hps_if.port),
		.io_wait  (io_wait),
		.io_fpga  (io_fpga),
		.io_uio   (io_uio),
		.io_strobe(io_strobe),
		.io_dout  (io_dout)
	);

endmodule

`default_nettype wire

// File: src/periph_regs.sv
/*
 * register page of the peripheral block
 * an access is taken on the first edge that samples cpu_valid, cpu_ready
 * follows one edge later for one cycle, the master holds the request till then
 * writes are whole words, cpu_wstrb only tells a write from a read
 * addresses outside the page or unmapped inside it read as zero
 */
`default_nettype none
`include "mcu_periph_params.svh"

module periph_regs (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire                            cpu_valid,
	input  wire mcu_periph_pkg::word_t     cpu_addr,
	input  wire mcu_periph_pkg::word_t     cpu_wdata,
	input  wire mcu_periph_pkg::wstrb_t    cpu_wstrb,
	output mcu_periph_pkg::word_t          cpu_rdata,
	output logic                           cpu_ready,
	output logic                           target_dataslot_read,
	output logic                           target_dataslot_write,
	input  wire                            target_dataslot_ack,
	input  wire                            target_dataslot_done,
	input  wire mcu_periph_pkg::slot_err_t target_dataslot_err,
	output mcu_periph_pkg::slot_id_t       target_dataslot_id,
	output mcu_periph_pkg::word_t          target_dataslot_slotoffset,
	output mcu_periph_pkg::word_t          target_dataslot_bridgeaddr,
	output mcu_periph_pkg::word_t          target_dataslot_length,
	output logic                           reset_out,
	input  wire                            io_wide,
	input  wire mcu_periph_pkg::io_data_t  io_din,
	output mcu_periph_pkg::word_t          tick_period,
	input  wire mcu_periph_pkg::word_t     timer_count,
	output logic                           timer_clear,
	dataslot_evt_if.consumer               evt,
	hps_io_if.controller                   hps
);
	import mcu_periph_pkg::*;

	logic             busy_q;     // access taken, ready next edge
	logic             start;
	logic             in_page;
	logic             is_write;
	logic [15:0]      reg_addr;
	word_t            rd_word;
	dataslot_status_t slot_status;
	hps_ctrl_t        hps_ctrl_q;
	io_data_t         hps_dout_q;
	logic             upd_ack_q;

	assign in_page  = cpu_addr[31:16] == `MCU_PAGE_HI;
	assign reg_addr = cpu_addr[15:0];
	assign is_write = |cpu_wstrb;
	assign start    = cpu_valid & ~busy_q & ~cpu_ready; // valid is still held while ready

	assign slot_status = {target_dataslot_ack, target_dataslot_done, target_dataslot_err};

	assign hps.io_clk = hps_ctrl_q.io_clk;
	assign hps.ss0    = hps_ctrl_q.ss0;
	assign hps.ss1    = hps_ctrl_q.ss1;
	assign hps.ss2    = hps_ctrl_q.ss2;
	assign hps.dout   = hps_dout_q;
	assign evt.ack    = upd_ack_q;

	// read mux
	always_comb begin
		rd_word = '0;
		if (in_page) begin
			case (reg_addr)
				`MCU_REG_SLOT_ID:     rd_word = {16'd0, target_dataslot_id};
				`MCU_REG_SLOT_BRIDGE: rd_word = target_dataslot_bridgeaddr;
				`MCU_REG_SLOT_LEN:    rd_word = target_dataslot_length;
				`MCU_REG_SLOT_OFS:    rd_word = target_dataslot_slotoffset;
				`MCU_REG_SLOT_CTRL:   rd_word = {27'd0, slot_status};
				`MCU_REG_TICK_PERIOD: rd_word = tick_period;
				`MCU_REG_RESET_OUT:   rd_word = {31'd0, reset_out};
				`MCU_REG_UPD_PENDING: rd_word = {31'd0, evt.pending};
				`MCU_REG_UPD_ID:      rd_word = {16'd0, evt.id};
				`MCU_REG_UPD_SIZE:    rd_word = evt.size;
				`MCU_REG_TIMER:       rd_word = timer_count;
				`MCU_REG_HPS_OUT:     rd_word = {11'd0, hps_ctrl_q, 1'b0, hps_dout_q};
				`MCU_REG_HPS_IN:      rd_word = {14'd0, hps.ack, io_wide, io_din};
				default:              rd_word = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			busy_q                     <= 1'b0;
			cpu_ready                  <= 1'b0;
			cpu_rdata                  <= '0;
			target_dataslot_read       <= 1'b0;
			target_dataslot_write      <= 1'b0;
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
			reset_out                  <= `MCU_RESET_OUT_RST;
			tick_period                <= `MCU_TICK_PERIOD_RST;
			timer_clear                <= 1'b0;
			hps_ctrl_q                 <= '0;
			hps_dout_q                 <= '0;
			upd_ack_q                  <= 1'b0;
		end else begin
			busy_q                <= start;
			cpu_ready             <= busy_q;
			target_dataslot_read  <= 1'b0; // pulses
			target_dataslot_write <= 1'b0;
			timer_clear           <= 1'b0;
			upd_ack_q             <= 1'b0;

			if (start && is_write && in_page) begin
				case (reg_addr)
					`MCU_REG_SLOT_ID:     target_dataslot_id <= cpu_wdata[15:0];
					`MCU_REG_SLOT_BRIDGE: target_dataslot_bridgeaddr <= cpu_wdata;
					`MCU_REG_SLOT_LEN:    target_dataslot_length <= cpu_wdata;
					`MCU_REG_SLOT_OFS:    target_dataslot_slotoffset <= cpu_wdata;
					`MCU_REG_SLOT_CTRL: begin
						target_dataslot_read  <= cpu_wdata[0];
						target_dataslot_write <= cpu_wdata[1];
					end
					`MCU_REG_TICK_PERIOD: tick_period <= cpu_wdata;
					`MCU_REG_RESET_OUT:   reset_out <= cpu_wdata[0];
					`MCU_REG_TIMER:       timer_clear <= cpu_wdata[0]; // timer clears next edge
					`MCU_REG_HPS_OUT: begin
						hps_ctrl_q <= hps_ctrl_t'(cpu_wdata[20:17]);
						hps_dout_q <= cpu_wdata[15:0];
					end
					default: ; // read only or unmapped
				endcase
			end

			if (start && !is_write) begin
				cpu_rdata <= rd_word;
				// reading a set pending clears it
				if (in_page && reg_addr == `MCU_REG_UPD_PENDING && evt.pending)
					upd_ack_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/hps_io_port.sv
/*
 * HPS strobe port
 * ss1 high deselects both targets
 * the strobe follows io_clk until rack catches up, one cycle at most
 * rack only moves while io_wait is low or the strobe is up
 * a held io_wait therefore keeps the ack back after the strobe
 */
`default_nettype none

module hps_io_port (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	hps_io_if.port                     hps,
	input  wire                        io_wait,
	output logic                       io_fpga,
	output logic                       io_uio,
	output logic                       io_strobe,
	output mcu_periph_pkg::io_data_t   io_dout
);

	logic rack_q; // registered io_clk
	logic ack_q;

	assign io_fpga   = ~hps.ss1 & hps.ss0; // commands to the core
	assign io_uio    = ~hps.ss1 & hps.ss2; // broadcast
	assign io_strobe = ~rack_q & hps.io_clk;
	assign io_dout   = hps.dout;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rack_q <= 1'b0;
			ack_q  <= 1'b0;
		end else if (!io_wait || io_strobe) begin
			rack_q <= hps.io_clk;
			ack_q  <= rack_q; // one cycle behind rack
		end
	end

	assign hps.ack = ack_q;

endmodule

`default_nettype wire

// File: src/ms_timer.sv
/*
 * millisecond timer
 * one ms is tick_period + 1 clk_sys cycles, a period of zero stops it
 * clear is synchronous and resets both counters
 */
`default_nettype none

module ms_timer (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire mcu_periph_pkg::word_t tick_period,
	input  wire                        clear,
	output mcu_periph_pkg::word_t      count // ms since clear
);
	import mcu_periph_pkg::*;

	word_t tick_q;  // cycles inside the current ms
	logic  running;

	assign running = tick_period != '0;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_q <= '0;
			count  <= '0;
		end else if (clear) begin
			tick_q <= '0;
			count  <= '0;
		end else if (running) begin
			if (tick_q == tick_period) begin // end of one ms
				tick_q <= '0;
				count  <= count + 1'b1;
			end else begin
				tick_q <= tick_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/dataslot_update_sync.sv
/*
 * dataslot update event from clk_74a into clk_sys
 * a source flag is held until pending is seen back in clk_74a
 * a second update before that merges into the first, only the latest
 * id and size are kept
 */
`default_nettype none

module dataslot_update_sync (
	input  wire                           clk_sys,
	input  wire                           clk_74a,
	input  wire                           reset_n,
	input  wire                           dataslot_update, // clk_74a pulse
	input  wire mcu_periph_pkg::slot_id_t dataslot_update_id,
	input  wire mcu_periph_pkg::word_t    dataslot_update_size,
	dataslot_evt_if.producer              evt
);
	import mcu_periph_pkg::*;

	logic       src_q;     // clk_74a flag
	logic [1:0] fb_q;      // pending back into clk_74a
	logic [1:0] sync_q;    // src_q into clk_sys
	logic       seen_q;    // last synced level
	logic       pending_q;

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			src_q <= 1'b0;
			fb_q  <= '0;
		end else begin
			fb_q <= {fb_q[0], pending_q};
			if (dataslot_update)
				src_q <= 1'b1;
			else if (fb_q[1]) // clk_sys has taken it
				src_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			sync_q    <= '0;
			seen_q    <= 1'b0;
			pending_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], src_q};
			seen_q <= sync_q[1];
			if (sync_q[1] && !seen_q) // rising edge only, a held flag sets once
				pending_q <= 1'b1;
			else if (evt.ack)
				pending_q <= 1'b0;
		end
	end

	assign evt.pending = pending_q;

	// three stages, so id and size settle together with pending
	cdc_value_latch #(.payload_t(slot_id_t)) u_id_latch (
		.write_clk(clk_74a),
		.read_clk (clk_sys),
		.reset_n  (reset_n),
		.capture  (dataslot_update),
		.din      (dataslot_update_id),
		.dout     (evt.id)
	);

	cdc_value_latch #(.payload_t(word_t)) u_size_latch (
		.write_clk(clk_74a),
		.read_clk (clk_sys),
		.reset_n  (reset_n),
		.capture  (dataslot_update),
		.din      (dataslot_update_size),
		.dout     (evt.size)
	);

endmodule

`default_nettype wire

// File: src/cdc_value_latch.sv
/*
 * value crossing from write_clk into read_clk
 * the value is held from one capture to the next and must stay stable long
 * enough to pass all read_clk stages, so only slow moving data fits here
 */
`default_nettype none
`include "mcu_periph_params.svh"

module cdc_value_latch #(
	parameter type payload_t = mcu_periph_pkg::word_t
) (
	input  wire           write_clk,
	input  wire           read_clk,
	input  wire           reset_n,
	input  wire           capture, // write_clk domain
	input  wire payload_t din,
	output payload_t      dout
);

	payload_t held_q;                     // write_clk side
	payload_t stage_q [`MCU_SYNC_STAGES]; // read_clk side

	always_ff @(posedge write_clk or negedge reset_n) begin
		if (!reset_n)
			held_q <= '0;
		else if (capture)
			held_q <= din;
	end

	always_ff @(posedge read_clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `MCU_SYNC_STAGES; i++)
				stage_q[i] <= '0;
		end else begin
			stage_q[0] <= held_q;
			for (int i = 1; i < `MCU_SYNC_STAGES; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign dout = stage_q[`MCU_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: src/mcu_periph_ifs.sv
/*
 * internal interfaces of the peripheral block
 * dataslot_evt_if carries the update event already in clk_sys
 * hps_io_if carries the HPS select and data lines and the returned ack
 */
`default_nettype none

interface dataslot_evt_if;
	import mcu_periph_pkg::*;

	logic     pending; // update seen, not yet read
	logic     ack;     // one cycle, pending was read
	slot_id_t id;
	word_t    size;

	modport producer (output pending, output id, output size, input ack);
	modport consumer (input pending, input id, input size, output ack);
endinterface

interface hps_io_if;
	import mcu_periph_pkg::*;

	logic     io_clk;
	logic     ss0;
	logic     ss1;
	logic     ss2;
	io_data_t dout;
	logic     ack; // strobe acknowledged by the far side

	modport controller (output io_clk, output ss0, output ss1, output ss2,
		output dout, input ack);
	modport port (input io_clk, input ss0, input ss1, input ss2,
		input dout, output ack);
endinterface

`default_nettype wire

// File: src/mcu_periph_pkg.sv
/*
 * shared types for the peripheral block
 * word_t is the bus width, all registers are read and written as whole words
 * the struct layouts match the bit positions of the status and HPS registers
 */
`default_nettype none

package mcu_periph_pkg;

	typedef logic [31:0] word_t;    // one bus word
	typedef logic [3:0]  wstrb_t;   // byte strobes, any bit set means write
	typedef logic [15:0] slot_id_t; // dataslot id
	typedef logic [2:0]  slot_err_t; // zero is OK
	typedef logic [15:0] io_data_t; // HPS data lines

	// read at SLOT_CTRL, bit 4 down to 0
	typedef struct packed {
		logic      ack;  // command in progress
		logic      done; // command finished
		slot_err_t err;
	} dataslot_status_t;

	// written at HPS_OUT bits 20..17
	typedef struct packed {
		logic ss2;
		logic ss1;
		logic ss0;
		logic io_clk; // also gates the strobe
	} hps_ctrl_t;

endpackage

`default_nettype wire

// File: src/mcu_periph_params.svh
/*
 * register map of the peripheral page and reset values
 * offsets are the low 16 address bits, the page is selected by the upper half
 * the testbench includes this header as well
 */
`ifndef MCU_PERIPH_PARAMS_SVH
`define MCU_PERIPH_PARAMS_SVH

`define MCU_PAGE_HI          16'hFFFF // upper address half of the page

// target dataslot command registers
`define MCU_REG_SLOT_ID      16'hFF80
`define MCU_REG_SLOT_BRIDGE  16'hFF84
`define MCU_REG_SLOT_LEN     16'hFF88
`define MCU_REG_SLOT_OFS     16'hFF8C
`define MCU_REG_SLOT_CTRL    16'hFF90 // write pulses, read status

`define MCU_REG_TICK_PERIOD  16'hFF98 // clk_sys cycles per ms, minus one
`define MCU_REG_RESET_OUT    16'hFFA4

// dataslot update notification, pending clears on read
`define MCU_REG_UPD_PENDING  16'hFFB0
`define MCU_REG_UPD_ID       16'hFFB4
`define MCU_REG_UPD_SIZE     16'hFFB8

`define MCU_REG_TIMER        16'hFFC8 // read count, write bit 0 clears
`define MCU_REG_HPS_OUT      16'hFFD0
`define MCU_REG_HPS_IN       16'hFFD4

`define MCU_TICK_PERIOD_RST  32'd0 // timer stopped out of reset
`define MCU_RESET_OUT_RST    1'b0

`define MCU_SYNC_STAGES      3 // clk_sys stages on the value crossing

`endif
